/* common/fpMulPkg.sv */
package fpMulPkg;

	// FP16 layout
	localparam int EXP_W = 5;
	localparam int MAN_W = 10;
	localparam int DATA_W = 1 + EXP_W + MAN_W;
	localparam int BIAS = 15;
	localparam int EXP_MAX = (1 << EXP_W) - 2; // Largest finite biased exponent
	localparam logic [EXP_W-1:0] EXP_ONES = '1; // Inf / NaN exponent
	localparam int PROD_W = 2 * MAN_W + 2; // Product of the two 11-bit significands

	// Vector sizing
	localparam int VEC_DEPTH = 16;
	localparam int IDX_W = 4;
	localparam int LEN_W = 5; // Holds 1..16

	localparam int FLAG_W = 5; // {any, aNan, bNan, aInf, bInf}
	localparam logic [MAN_W-1:0] QNAN_MAN = 10'h200; // Canonical quiet NaN payload

	typedef enum logic [1:0] {
		CMD_WR_A,
		CMD_WR_B,
		CMD_START, // data carries the run length
		CMD_RD
	} hostOp_e;

	typedef enum logic [1:0] {
		IDLE,
		RUN, // Issuing one element per cycle
		DRAIN // Waiting for the pipeline to empty
	} ctrlState_e;

	// One host command
	typedef struct packed {
		hostOp_e op;
		logic [IDX_W-1:0] idx;
		logic [DATA_W-1:0] data;
	} hostCmd_t;

	// Sideband that rides alongside each item in the multiplier
	typedef struct packed {
		logic valid;
		logic [IDX_W-1:0] idx;
	} mulMeta_t;

	typedef struct packed {
		logic valid;
		logic [IDX_W-1:0] idx;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
	} mulIn_t;

	typedef struct packed {
		logic valid;
		logic [IDX_W-1:0] idx;
		logic [DATA_W-1:0] prod;
		logic [FLAG_W-1:0] flags;
	} mulOut_t;

	// Product plus flags, also used inside the multiplier after rounding
	typedef struct packed {
		logic [DATA_W-1:0] prod;
		logic [FLAG_W-1:0] flags;
	} rdResp_t;

endpackage

/* fpMult/fpMultPrep.sv */
module fpMultPrep import fpMulPkg::*; (
	input logic clk,
	input logic rst,
	input mulIn_t in,
	output logic sign,
	output logic [EXP_W:0] expSum, // Biased sum, bias removed later
	output logic [PROD_W-1:0] manProd,
	output logic [FLAG_W-1:0] exc,
	output logic zero,
	output mulMeta_t meta
);
	mulMeta_t meta1;
	logic [DATA_W-1:0] a1; // Stage 1 operands
	logic [DATA_W-1:0] b1;
	logic [EXP_W-1:0] expA;
	logic [EXP_W-1:0] expB;
	logic [MAN_W-1:0] manA;
	logic [MAN_W-1:0] manB;
	logic aNan;
	logic bNan;
	logic aInf;
	logic bInf;

	// Stage 1 registers the raw operands
	always_ff @(posedge clk) begin
		if (rst) meta1 <= '0;
		else meta1 <= '{valid: in.valid, idx: in.idx};
	end

	always_ff @(posedge clk) begin
		a1 <= in.a;
		b1 <= in.b;
	end

	// Field split
	assign expA = a1[DATA_W-2 -: EXP_W];
	assign expB = b1[DATA_W-2 -: EXP_W];
	assign manA = a1[MAN_W-1:0];
	assign manB = b1[MAN_W-1:0];

	// Exponent all ones, mantissa decides NaN vs Inf
	assign aNan = (expA == EXP_ONES) && (manA != '0);
	assign bNan = (expB == EXP_ONES) && (manB != '0);
	assign aInf = (expA == EXP_ONES) && (manA == '0);
	assign bInf = (expB == EXP_ONES) && (manB == '0);

	// Stage 2 sideband
	always_ff @(posedge clk) begin
		if (rst) meta <= '0;
		else meta <= meta1;
	end

	// Stage 2 execute
	always_ff @(posedge clk) begin
		sign <= a1[DATA_W-1] ^ b1[DATA_W-1];
		expSum <= expA + expB;
		manProd <= {1'b1, manA} * {1'b1, manB}; // Hidden ones restored
		exc <= {aNan | bNan | aInf | bInf, aNan, bNan, aInf, bInf};
		zero <= (expA == '0) || (expB == '0); // Denormals count as zero
	end

endmodule

/* fpMult/fpMultRound.sv */
module fpMultRound import fpMulPkg::*; (
	input logic [PROD_W-1:0] manProd,
	input logic [EXP_W:0] expSum,
	input logic sign,
	input logic [FLAG_W-1:0] exc,
	input logic zero,
	output rdResp_t out
);
	logic top; // Product in [2,4)
	logic [MAN_W-1:0] manNorm;
	logic guard;
	logic sticky;
	logic roundUp;
	logic [MAN_W:0] manRnd; // One extra bit for the round carry
	logic carry;
	logic [EXP_W+1:0] expAdj;
	logic [EXP_W+1:0] expUnb; // Two's complement after bias removal
	logic underflow;
	logic overflow;

	// Normalize on the top product bit
	assign top = manProd[PROD_W-1];
	assign manNorm = top ? manProd[PROD_W-2 -: MAN_W] : manProd[PROD_W-3 -: MAN_W];
	assign guard = top ? manProd[MAN_W] : manProd[MAN_W-1];
	assign sticky = top ? |manProd[MAN_W-1:0] : |manProd[MAN_W-2:0];

	// Nearest even
	assign roundUp = guard & (sticky | manNorm[0]);
	assign manRnd = {1'b0, manNorm} + {{MAN_W{1'b0}}, roundUp};
	assign carry = manRnd[MAN_W]; // All ones rolled over, fraction is already zero

	assign expAdj = {1'b0, expSum} + {{(EXP_W+1){1'b0}}, top} + {{(EXP_W+1){1'b0}}, carry};
	assign expUnb = expAdj - (EXP_W+2)'(BIAS);

	// Range checks on the final exponent
	assign underflow = expUnb[EXP_W+1] || (expUnb == '0);
	assign overflow = !expUnb[EXP_W+1] && (expUnb > (EXP_W+2)'(EXP_MAX));

	always_comb begin
		out.flags = exc; // Flags pass straight through
		if (exc[FLAG_W-1]) begin
			out.prod = {sign, EXP_ONES, QNAN_MAN}; // Any NaN or Inf input
		end else if (zero || underflow) begin
			out.prod = {sign, {(DATA_W-1){1'b0}}}; // Signed zero
		end else if (overflow) begin
			out.prod = {sign, EXP_ONES, {MAN_W{1'b0}}}; // Saturate to Inf
		end else begin
			out.prod = {sign, expUnb[EXP_W-1:0], manRnd[MAN_W-1:0]};
		end
	end

endmodule

/* fpMult/fpMult.sv */
module fpMult import fpMulPkg::*; (
	input logic clk,
	input logic rst,
	input mulIn_t in,
	output mulOut_t out
);
	logic sign2;
	logic [EXP_W:0] expSum2;
	logic [PROD_W-1:0] manProd2;
	logic [FLAG_W-1:0] exc2;
	logic zero2;
	mulMeta_t meta2;

	// Stage 3 copy of the execute result
	logic sign3;
	logic [EXP_W:0] expSum3;
	logic [PROD_W-1:0] manProd3;
	logic [FLAG_W-1:0] exc3;
	logic zero3;
	mulMeta_t meta3;

	rdResp_t roundRes;
	rdResp_t res4;
	rdResp_t res5;
	mulMeta_t meta4;
	mulMeta_t meta5;

	fpMultPrep uPrep (
		.clk(clk),
		.rst(rst),
		.in(in),
		.sign(sign2),
		.expSum(expSum2),
		.manProd(manProd2),
		.exc(exc2),
		.zero(zero2),
		.meta(meta2)
	);

	// Valid and index move with the data through stages 3..5
	always_ff @(posedge clk) begin
		if (rst) begin
			meta3 <= '0;
			meta4 <= '0;
			meta5 <= '0;
		end else begin
			meta3 <= meta2;
			meta4 <= meta3;
			meta5 <= meta4;
		end
	end

	always_ff @(posedge clk) begin
		sign3 <= sign2;
		expSum3 <= expSum2;
		manProd3 <= manProd2;
		exc3 <= exc2;
		zero3 <= zero2;
		res4 <= roundRes; // Stage 4 rounded value
		res5 <= res4; // Output register
	end

	fpMultRound uRound (
		.manProd(manProd3),
		.expSum(expSum3),
		.sign(sign3),
		.exc(exc3),
		.zero(zero3),
		.out(roundRes)
	);

	assign out = '{valid: meta5.valid, idx: meta5.idx, prod: res5.prod, flags: res5.flags};

endmodule

/* logic/operandBuf.sv */
module operandBuf import fpMulPkg::*; (
	input logic clk,
	input logic wrA,
	input logic wrB,
	input logic [IDX_W-1:0] wrIdx,
	input logic [DATA_W-1:0] wrData,
	input logic rdEn,
	input logic [IDX_W-1:0] rdIdx,
	output logic [DATA_W-1:0] opA,
	output logic [DATA_W-1:0] opB
);
	logic [DATA_W-1:0] memA [VEC_DEPTH];
	logic [DATA_W-1:0] memB [VEC_DEPTH];

	// Host side writes
	always_ff @(posedge clk) begin
		if (wrA) memA[wrIdx] <= wrData;
		if (wrB) memB[wrIdx] <= wrData;
	end

	// Paired read, both vectors at the same index
	always_ff @(posedge clk) begin
		if (rdEn) begin
			opA <= memA[rdIdx];
			opB <= memB[rdIdx];
		end
	end

endmodule

/* logic/resultBuf.sv */
module resultBuf import fpMulPkg::*; (
	input logic clk,
	input mulOut_t res,
	input logic rdEn,
	input logic [IDX_W-1:0] rdIdx,
	output rdResp_t rdResp
);
	rdResp_t mem [VEC_DEPTH]; // Product and flags per element

	// Written straight from the multiplier output
	always_ff @(posedge clk) begin
		if (res.valid) mem[res.idx] <= '{prod: res.prod, flags: res.flags};
	end

	// Host read, one cycle latency
	always_ff @(posedge clk) begin
		if (rdEn) rdResp <= mem[rdIdx];
	end

endmodule

/* logic/vecCtrl.sv */
module vecCtrl import fpMulPkg::*; (
	input logic clk,
	input logic rst,
	input logic cmdStrobe,
	input hostCmd_t cmd,
	input logic [DATA_W-1:0] opA,
	input logic [DATA_W-1:0] opB,
	input logic retire, // Valid bit at the multiplier output
	output logic wrA,
	output logic wrB,
	output logic [IDX_W-1:0] wrIdx,
	output logic [DATA_W-1:0] wrData,
	output logic bufRdEn,
	output logic [IDX_W-1:0] bufRdIdx,
	output mulIn_t mulIn,
	output logic resRdEn,
	output logic [IDX_W-1:0] resRdIdx,
	output logic rdValid,
	output logic busy,
	output logic done
);
	ctrlState_e state;
	logic [LEN_W-1:0] runLen; // Latched at start
	logic [LEN_W-1:0] startLen;
	logic [LEN_W-1:0] issueCnt;
	logic [LEN_W-1:0] retireCnt;
	logic idle;
	logic startOk;
	logic lastIssue;
	logic lastRetire;
	logic issueVld; // Read enable delayed to match buffer latency
	logic [IDX_W-1:0] issueIdx;

	assign idle = (state == IDLE);
	assign busy = !idle;

	// Host decode, only writes and start are filtered by busy
	assign wrA = cmdStrobe && idle && (cmd.op == CMD_WR_A);
	assign wrB = cmdStrobe && idle && (cmd.op == CMD_WR_B);
	assign wrIdx = cmd.idx;
	assign wrData = cmd.data;
	assign resRdEn = cmdStrobe && (cmd.op == CMD_RD);
	assign resRdIdx = cmd.idx;

	assign startLen = cmd.data[LEN_W-1:0];
	assign startOk = cmdStrobe && idle && (cmd.op == CMD_START) &&
		(startLen != '0) && (startLen <= LEN_W'(VEC_DEPTH)); // Bad lengths dropped

	// Issue one element per cycle while in RUN
	assign bufRdEn = (state == RUN);
	assign bufRdIdx = issueCnt[IDX_W-1:0];
	assign lastIssue = (issueCnt == runLen - 1'b1);
	assign lastRetire = retire && (retireCnt == runLen - 1'b1);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			runLen <= '0;
			issueCnt <= '0;
			retireCnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0; // Single cycle pulse
			case (state)
				IDLE: begin
					if (startOk) begin
						state <= RUN;
						runLen <= startLen;
						issueCnt <= '0;
						retireCnt <= '0;
					end
				end
				RUN: begin
					issueCnt <= issueCnt + 1'b1;
					if (lastIssue) state <= DRAIN;
				end
				DRAIN: ; // Retire logic below ends the run
				default: state <= IDLE;
			endcase
			// Count products leaving the multiplier
			if (!idle && retire) begin
				retireCnt <= retireCnt + 1'b1;
				if (lastRetire) begin
					state <= IDLE;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			issueVld <= 1'b0;
			rdValid <= 1'b0;
		end else begin
			issueVld <= bufRdEn;
			rdValid <= resRdEn; // Lines up with the result buffer read
		end
	end

	always_ff @(posedge clk) issueIdx <= bufRdIdx;

	// Operands arrive one cycle after the read
	assign mulIn = '{valid: issueVld, idx: issueIdx, a: opA, b: opB};

endmodule

/* logic/vecMulTop.sv */
module vecMulTop import fpMulPkg::*; (
	input logic clk,
	input logic rst,
	input logic cmdStrobe,
	input hostCmd_t cmd,
	output logic rdValid,
	output rdResp_t rdResp,
	output logic busy,
	output logic done
);
	logic wrA;
	logic wrB;
	logic [IDX_W-1:0] wrIdx;
	logic [DATA_W-1:0] wrData;
	logic bufRdEn;
	logic [IDX_W-1:0] bufRdIdx;
	logic [DATA_W-1:0] opA;
	logic [DATA_W-1:0] opB;
	mulIn_t mulIn;
	mulOut_t mulOut;
	logic resRdEn;
	logic [IDX_W-1:0] resRdIdx;

	vecCtrl uCtrl (
		.clk(clk),
		.rst(rst),
		.cmdStrobe(cmdStrobe),
		.cmd(cmd),
		.opA(opA),
		.opB(opB),
		.retire(mulOut.valid), // Retire count comes from the output valid
		.wrA(wrA),
		.wrB(wrB),
		.wrIdx(wrIdx),
		.wrData(wrData),
		.bufRdEn(bufRdEn),
		.bufRdIdx(bufRdIdx),
		.mulIn(mulIn),
		.resRdEn(resRdEn),
		.resRdIdx(resRdIdx),
		.rdValid(rdValid),
		.busy(busy),
		.done(done)
	);

	operandBuf uOpBuf (
		.clk(clk),
		.wrA(wrA),
		.wrB(wrB),
		.wrIdx(wrIdx),
		.wrData(wrData),
		.rdEn(bufRdEn),
		.rdIdx(bufRdIdx),
		.opA(opA),
		.opB(opB)
	);

	fpMult uMult (
		.clk(clk),
		.rst(rst),
		.in(mulIn),
		.out(mulOut)
	);

	resultBuf uResBuf (
		.clk(clk),
		.res(mulOut),
		.rdEn(resRdEn),
		.rdIdx(resRdIdx),
		.rdResp(rdResp)
	);

endmodule

/* tests/vecMulTb_chk.sv */
module vecMulTb_chk import fpMulPkg::*; (
	input logic clk,
	input logic rst,
	input logic cmdStrobe,
	input hostCmd_t cmd,
	input logic retire,
	input logic issueVld,
	input logic rdValid,
	input logic busy,
	input logic done
);
	timeunit 1ns;
	timeprecision 1ps;

	// Done is a one-cycle pulse
	doneOneCycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done stayed high for more than one cycle");

	// Every retire is followed by more run time or by done
	doneAfterLast: assert property (@(posedge clk) disable iff (rst)
		retire |=> (busy || done))
		else $error("a product was written after done");

	// Read response one cycle after a host read strobe
	readResponse: assert property (@(posedge clk) disable iff (rst)
		rdValid == $past(cmdStrobe && (cmd.op == CMD_RD)))
		else $error("rdValid did not follow the read strobe by one cycle");

	// Nothing enters or leaves the multiplier while idle
	idleQuiet: assert property (@(posedge clk) disable iff (rst)
		!busy |-> (!issueVld && !retire))
		else $error("multiplier traffic while the engine is not busy");

endmodule

bind vecCtrl vecMulTb_chk uChk (
	.clk(clk),
	.rst(rst),
	.cmdStrobe(cmdStrobe),
	.cmd(cmd),
	.retire(retire),
	.issueVld(issueVld),
	.rdValid(rdValid),
	.busy(busy),
	.done(done)
);

/* tests/vecMulTb.sv */
module vecMulTb import fpMulPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam string TEST_FILE = "tests/vecMulTests.txt";

	logic clk;
	logic rst;
	logic cmdStrobe;
	hostCmd_t cmd;
	logic rdValid;
	rdResp_t rdResp;
	logic busy;
	logic done;

	// Per test name and length, elements of all tests back to back
	string testName [$];
	int testLen [$];
	logic [DATA_W-1:0] vecA [$];
	logic [DATA_W-1:0] vecB [$];
	logic [DATA_W-1:0] expProd [$];
	logic [FLAG_W-1:0] expFlags [$];

	logic [31:0] lcgState = 32'h3dd9;
	int cycles = 0;
	int cycleLimit = 0; // Worked out from the test lengths at time 0
	int doneCount = 0;
	int errors = 0;
	int passedTests = 0;

	vecMulTop i_dut (
		.clk(clk),
		.rst(rst),
		.cmdStrobe(cmdStrobe),
		.cmd(cmd),
		.rdValid(rdValid),
		.rdResp(rdResp),
		.busy(busy),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Cycle watchdog and done counter
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (done) doneCount <= doneCount + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles, the run never finished", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223; // LCG step
	endfunction

	task automatic loadTests(output bit ok);
		int fd;
		int len;
		int remaining;
		string line;
		string name;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] p;
		logic [FLAG_W-1:0] f;
		remaining = 0;
		fd = $fopen(TEST_FILE, "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 3 || line[0] == "#") continue; // Blank or comment
				if (remaining == 0) begin
					if ($sscanf(line, "%s %d", name, len) == 2) begin
						testName.push_back(name);
						testLen.push_back(len);
						remaining = len;
					end
				end else if ($sscanf(line, "%h %h %h %h", a, b, p, f) == 4) begin
					vecA.push_back(a);
					vecB.push_back(b);
					expProd.push_back(p);
					expFlags.push_back(f);
					remaining--;
				end
			end
			$fclose(fd);
		end
	endtask

	// Called on a falling edge, returns on the next one
	task automatic sendCmd(input hostOp_e cmdOp, input logic [IDX_W-1:0] cmdIdx,
		input logic [DATA_W-1:0] cmdData);
		cmdStrobe = 1'b1;
		cmd = '{op: cmdOp, idx: cmdIdx, data: cmdData};
		@(negedge clk);
		cmdStrobe = 1'b0;
	endtask

	task automatic runTest(input int t, input int base);
		int len;
		int startErrors;
		int expDone;
		logic [DATA_W-1:0] dataA;
		logic [DATA_W-1:0] dataB;
		len = testLen[t];
		startErrors = errors;
		expDone = doneCount + 1;
		for (int i = 0; i < VEC_DEPTH; i++) begin
			if (i < len) begin
				dataA = vecA[base + i];
				dataB = vecB[base + i];
			end else begin
				lcgState = nextRandom(lcgState); // Unused entries get noise
				dataA = lcgState[31:16];
				lcgState = nextRandom(lcgState);
				dataB = lcgState[31:16];
			end
			sendCmd(CMD_WR_A, IDX_W'(i), dataA);
			sendCmd(CMD_WR_B, IDX_W'(i), dataB);
		end
		sendCmd(CMD_START, '0, DATA_W'(len));
		assert (busy) else begin
			$display("Engine did not go busy after the start of %s", testName[t]);
			errors++;
		end
		// Both must be dropped while busy
		sendCmd(CMD_WR_A, IDX_W'(len - 1), ~vecA[base + len - 1]); // Last element not read yet
		sendCmd(CMD_START, '0, DATA_W'(VEC_DEPTH));
		while (!done) @(negedge clk);
		assert (!busy) else begin
			$display("Engine still busy after the done of %s", testName[t]);
			errors++;
		end
		for (int i = 0; i < len; i++) begin
			sendCmd(CMD_RD, IDX_W'(i), '0);
			assert (rdValid) else begin
				$display("No rdValid for the read of %s element %0d", testName[t], i);
				errors++;
			end
			assert (rdResp.prod == expProd[base + i] &&
				rdResp.flags == expFlags[base + i]) else begin
				$display("MISMATCH at %0t: %s[%0d] got %h flags %h, expected %h flags %h",
					$time, testName[t], i, rdResp.prod, rdResp.flags,
					expProd[base + i], expFlags[base + i]);
				errors++;
			end
		end
		repeat (8) @(negedge clk); // Room for a stray second done
		assert (doneCount == expDone) else begin
			$display("Test %s saw %0d done pulses instead of one", testName[t],
				doneCount - expDone + 1);
			errors++;
		end
		if (errors == startErrors) begin
			passedTests++;
			$display("Test %s len %0d ok", testName[t], len);
		end else begin
			$display("Test %s len %0d had %0d errors", testName[t], len, errors - startErrors);
		end
	endtask

	initial begin
		bit opened;
		int base;
		rst = 1'b1;
		cmdStrobe = 1'b0;
		cmd = '0;
		loadTests(opened);
		foreach (testLen[t]) cycleLimit += 2 * (2 * testLen[t] + testLen[t] + 20);
		if (!opened || testName.size() == 0) begin
			$display("Could not read any test from %s", TEST_FILE);
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			repeat (10) @(negedge clk);
			rst = 1'b0;
			base = 0;
			foreach (testName[t]) begin
				runTest(t, base);
				base += testLen[t];
			end
			$display("%0d of %0d tests passed, %0d errors", passedTests, testName.size(), errors);
			if (errors == 0) begin
				$display("TESTBENCH PASSED");
			end else begin
				$display("TESTBENCH FAILED");
			end
			$finish;
		end
	end

endmodule

/* tests/vecMulTests.txt */
# Each record is a test name and run length, then one line per element
# Element columns are A, B, expected product and expected flags {any aNan bNan aInf bInf} in hex
mixed16 16
3E00 4000 4200 00
C200 3800 BE00 00
C000 C000 4400 00
3C01 3E00 3E02 00
3C03 3E00 3E04 00
3DA8 3DA8 4000 00
7E00 3C00 7E00 18
C000 7C01 FE00 14
7C00 4000 7E00 12
3C00 FC00 FE00 11
0000 4200 0000 00
8000 4200 8000 00
7800 7800 7C00 00
F800 7800 FC00 00
0400 0400 0000 00
8400 0400 8000 00

single1 1
7BFF 3C00 7BFF 00

short4 4
4500 4600 4F80 00
7C00 7C00 7E00 13
2000 1C00 0000 00
4900 C900 D640 00

/* project.f */
common/fpMulPkg.sv
fpMult/fpMultPrep.sv
fpMult/fpMultRound.sv
fpMult/fpMult.sv
logic/operandBuf.sv
logic/resultBuf.sv
logic/vecCtrl.sv
logic/vecMulTop.sv
tests/vecMulTb_chk.sv
tests/vecMulTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= vecMulTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "TESTBENCH FAILED" $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
